// File: src/game_control.sv
`timescale 1ns/1ps
`default_nettype none

module game_control
    import mastermind_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  resetn,
    input  wire logic  load_i,
    output load_ctrl_t load_ctrl_o,
    output score_ctrl_t score_ctrl_o,
    output logic       result_o
);

    game_state_e state_q;
    game_state_e state_d;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state_q <= code_wait_1;
        end else begin
            state_q <= state_d;
        end
    end

    // wait states move on a press, hold states on the release
    always_comb begin
        state_d = state_q;
        case (state_q)
            code_wait_1:  if (load_i) state_d = code_hold_1;
            code_hold_1:  if (!load_i) state_d = code_wait_2;
            code_wait_2:  if (load_i) state_d = code_hold_2;
            code_hold_2:  if (!load_i) state_d = code_wait_3;
            code_wait_3:  if (load_i) state_d = code_hold_3;
            code_hold_3:  if (!load_i) state_d = code_wait_4;
            code_wait_4:  if (load_i) state_d = code_hold_4;
            code_hold_4:  if (!load_i) state_d = guess_wait_1;
            guess_wait_1: if (load_i) state_d = guess_hold_1;
            guess_hold_1: if (!load_i) state_d = guess_wait_2;
            guess_wait_2: if (load_i) state_d = guess_hold_2;
            guess_hold_2: if (!load_i) state_d = guess_wait_3;
            guess_wait_3: if (load_i) state_d = guess_hold_3;
            guess_hold_3: if (!load_i) state_d = guess_wait_4;
            guess_wait_4: if (load_i) state_d = guess_hold_4;
            guess_hold_4: if (!load_i) state_d = score_1;
            score_1:      state_d = score_2;
            score_2:      state_d = score_3;
            score_3:      state_d = score_4;
            score_4:      state_d = result;
            result:       state_d = guess_wait_1;
            default:      state_d = code_wait_1;
        endcase
    end

    always_comb begin
        load_ctrl_o = '0;
        score_ctrl_o = '0;
        result_o = 1'b0;
        case (state_q)
            code_wait_1: begin
                load_ctrl_o.code_en = 1'b1;
                load_ctrl_o.index = 2'd0;
            end
            code_wait_2: begin
                load_ctrl_o.code_en = 1'b1;
                load_ctrl_o.index = 2'd1;
            end
            code_wait_3: begin
                load_ctrl_o.code_en = 1'b1;
                load_ctrl_o.index = 2'd2;
            end
            code_wait_4: begin
                load_ctrl_o.code_en = 1'b1;
                load_ctrl_o.index = 2'd3;
            end
            guess_wait_1: begin
                load_ctrl_o.guess_en = 1'b1;
                load_ctrl_o.index = 2'd0;
            end
            guess_wait_2: begin
                load_ctrl_o.guess_en = 1'b1;
                load_ctrl_o.index = 2'd1;
            end
            guess_wait_3: begin
                load_ctrl_o.guess_en = 1'b1;
                load_ctrl_o.index = 2'd2;
            end
            guess_wait_4: begin
                load_ctrl_o.guess_en = 1'b1;
                load_ctrl_o.index = 2'd3;
                // last guess peg pending, old score goes
                score_ctrl_o.clear = 1'b1;
            end
            score_1: begin
                score_ctrl_o.step = 1'b1;
                score_ctrl_o.index = 2'd0;
            end
            score_2: begin
                score_ctrl_o.step = 1'b1;
                score_ctrl_o.index = 2'd1;
            end
            score_3: begin
                score_ctrl_o.step = 1'b1;
                score_ctrl_o.index = 2'd2;
            end
            score_4: begin
                score_ctrl_o.step = 1'b1;
                score_ctrl_o.index = 2'd3;
            end
            result: begin
                result_o = 1'b1;
            end
            default: begin
                result_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/mastermind_pkg.sv
`default_nettype none

package mastermind_pkg;

    localparam int num_pegs = 4;

    typedef logic [2:0] peg_t;
    typedef logic [1:0] peg_idx_t;
    // position 0 in the low bits
    typedef peg_t [num_pegs-1:0] pegs_t;
    typedef logic [2:0] count_t;
    typedef logic [2:0] round_t;
    // active low, segment 0 in bit 0
    typedef logic [6:0] seg_t;

    typedef struct packed {
        count_t red;
        count_t white;
    } score_t;

    // which peg register captures peg data this cycle
    typedef struct packed {
        logic     code_en;
        logic     guess_en;
        peg_idx_t index;
    } load_ctrl_t;

    typedef struct packed {
        logic     clear;
        logic     step;
        peg_idx_t index;
    } score_ctrl_t;

    typedef enum logic [4:0] {
        code_wait_1, code_hold_1, code_wait_2, code_hold_2,
        code_wait_3, code_hold_3, code_wait_4, code_hold_4,
        guess_wait_1, guess_hold_1, guess_wait_2, guess_hold_2,
        guess_wait_3, guess_hold_3, guess_wait_4, guess_hold_4,
        score_1, score_2, score_3, score_4,
        result
    } game_state_e;

endpackage

`default_nettype wire

// File: src/mastermind_top.sv
`timescale 1ns/1ps
`default_nettype none

module mastermind_top
    import mastermind_pkg::*;
(
    input  wire logic clock,
    input  wire logic resetn,
    input  wire logic load_i,
    input  wire peg_t peg_i,
    output seg_t [5:0] hex_o,
    output score_t    score_o,
    output round_t    round_o,
    output logic      result_valid_o
);

    load_ctrl_t  load_ctrl;
    score_ctrl_t score_ctrl;
    logic        result_strobe;
    pegs_t       guess;
    peg_t        code_peg;
    score_t      score;
    logic [5:0][3:0] digits;

    game_control u_game_control (
        .clock        (clock),
        .resetn       (resetn),
        .load_i       (load_i),
        .load_ctrl_o  (load_ctrl),
        .score_ctrl_o (score_ctrl),
        .result_o     (result_strobe)
    );

    peg_registers u_peg_registers (
        .clock        (clock),
        .resetn       (resetn),
        .load_ctrl_i  (load_ctrl),
        .peg_i        (peg_i),
        .code_idx_i   (score_ctrl.index),
        .round_step_i (result_strobe),
        .guess_o      (guess),
        .code_peg_o   (code_peg),
        .round_o      (round_o)
    );

    peg_scorer u_peg_scorer (
        .clock        (clock),
        .resetn       (resetn),
        .score_ctrl_i (score_ctrl),
        .code_peg_i   (code_peg),
        .guess_i      (guess),
        .score_o      (score)
    );

    // digits 0-3 guess pegs, 4 red, 5 white
    assign digits[0] = {1'b0, guess[0]};
    assign digits[1] = {1'b0, guess[1]};
    assign digits[2] = {1'b0, guess[2]};
    assign digits[3] = {1'b0, guess[3]};
    assign digits[4] = {1'b0, score.red};
    assign digits[5] = {1'b0, score.white};

    for (genvar i = 0; i < 6; i++) begin : g_hex
        seven_seg_decoder u_dec (
            .digit_i (digits[i]),
            .seg_o   (hex_o[i])
        );
    end

    assign score_o = score;
    assign result_valid_o = result_strobe;

endmodule

`default_nettype wire

// File: src/peg_registers.sv
`timescale 1ns/1ps
`default_nettype none

module peg_registers
    import mastermind_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       resetn,
    input  wire load_ctrl_t load_ctrl_i,
    input  wire peg_t       peg_i,
    input  wire peg_idx_t   code_idx_i,
    input  wire logic       round_step_i,
    output pegs_t           guess_o,
    output peg_t            code_peg_o,
    output round_t          round_o
);

    pegs_t  code_q;
    pegs_t  guess_q;
    round_t round_q;

    // addressed peg follows peg_i while its wait state lasts
    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_q <= '0;
            guess_q <= '0;
        end else begin
            if (load_ctrl_i.code_en) begin
                code_q[load_ctrl_i.index] <= peg_i;
            end
            if (load_ctrl_i.guess_en) begin
                guess_q[load_ctrl_i.index] <= peg_i;
            end
        end
    end

    // wraps 7 to 0 on its own
    always_ff @(posedge clock) begin
        if (!resetn) begin
            round_q <= '0;
        end else if (round_step_i) begin
            round_q <= round_q + round_t'(1);
        end
    end

    assign guess_o = guess_q;
    assign code_peg_o = code_q[code_idx_i];
    assign round_o = round_q;

endmodule

`default_nettype wire

// File: src/peg_scorer.sv
`timescale 1ns/1ps
`default_nettype none

module peg_scorer
    import mastermind_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        resetn,
    input  wire score_ctrl_t score_ctrl_i,
    input  wire peg_t        code_peg_i,
    input  wire pegs_t       guess_i,
    output score_t           score_o
);

    // guess position consumed by a red or a white
    logic [num_pegs-1:0] used_q;
    // position already scored red
    logic [num_pegs-1:0] exact_q;
    // code peg consumed by a white
    logic [num_pegs-1:0] code_used_q;
    pegs_t               code_hist_q;
    count_t              red_q;
    count_t              white_q;

    peg_idx_t            k;
    logic                hit;
    logic [num_pegs-1:0] guess_cand;
    logic [num_pegs-1:0] code_cand;
    peg_idx_t            guess_sel;
    peg_idx_t            code_sel;
    logic                guess_found;
    logic                code_found;

    assign k = score_ctrl_i.index;
    assign hit = (code_peg_i == guess_i[k]);

    // only positions below k have a known exact status,
    // so whites pair the new code peg and the new guess peg with those
    always_comb begin
        guess_cand = '0;
        code_cand = '0;
        for (int j = 0; j < num_pegs; j++) begin
            if (peg_idx_t'(j) < k) begin
                guess_cand[j] = !used_q[j] && (guess_i[j] == code_peg_i);
                code_cand[j] = !exact_q[j] && !code_used_q[j] &&
                               (code_hist_q[j] == guess_i[k]);
            end
        end
    end

    // lowest index wins
    always_comb begin
        guess_sel = '0;
        code_sel = '0;
        for (int j = num_pegs - 1; j >= 0; j--) begin
            if (guess_cand[j]) begin
                guess_sel = peg_idx_t'(j);
            end
            if (code_cand[j]) begin
                code_sel = peg_idx_t'(j);
            end
        end
    end

    assign guess_found = |guess_cand;
    assign code_found = |code_cand;

    always_ff @(posedge clock) begin
        if (!resetn || score_ctrl_i.clear) begin
            used_q <= '0;
            exact_q <= '0;
            code_used_q <= '0;
            red_q <= '0;
            white_q <= '0;
        end else if (score_ctrl_i.step) begin
            if (hit) begin
                red_q <= red_q + count_t'(1);
                used_q[k] <= 1'b1;
                exact_q[k] <= 1'b1;
            end else begin
                white_q <= white_q + count_t'(guess_found) + count_t'(code_found);
                if (guess_found) begin
                    used_q[guess_sel] <= 1'b1;
                    code_used_q[k] <= 1'b1;
                end
                if (code_found) begin
                    code_used_q[code_sel] <= 1'b1;
                    used_q[k] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (score_ctrl_i.step) begin
            code_hist_q[k] <= code_peg_i;
        end
    end

    assign score_o = '{red: red_q, white: white_q};

endmodule

`default_nettype wire

// File: src/seven_seg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module seven_seg_decoder
    import mastermind_pkg::*;
(
    input  wire logic [3:0] digit_i,
    output seg_t            seg_o
);

    // segments are active low
    always_comb begin
        case (digit_i)
            4'h0:    seg_o = 7'b100_0000;
            4'h1:    seg_o = 7'b111_1001;
            4'h2:    seg_o = 7'b010_0100;
            4'h3:    seg_o = 7'b011_0000;
            4'h4:    seg_o = 7'b001_1001;
            4'h5:    seg_o = 7'b001_0010;
            4'h6:    seg_o = 7'b000_0010;
            4'h7:    seg_o = 7'b111_1000;
            4'h8:    seg_o = 7'b000_0000;
            4'h9:    seg_o = 7'b001_1000;
            4'ha:    seg_o = 7'b000_1000;
            4'hb:    seg_o = 7'b000_0011;
            4'hc:    seg_o = 7'b100_0110;
            4'hd:    seg_o = 7'b010_0001;
            4'he:    seg_o = 7'b000_0110;
            4'hf:    seg_o = 7'b000_1110;
            default: seg_o = 7'b111_1111;
        endcase
    end

endmodule

`default_nettype wire

// File: tb.f
src/mastermind_pkg.sv
src/seven_seg_decoder.sv
src/game_control.sv
src/peg_registers.sv
src/peg_scorer.sv
src/mastermind_top.sv
tests/mastermind_assert.sv
tests/mastermind_tb.sv

// File: tests/mastermind_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mastermind_assert
    import mastermind_pkg::*;
(
    input wire logic        clock,
    input wire logic        resetn,
    input wire score_ctrl_t score_ctrl_i,
    input wire logic        result_i,
    input wire score_t      score_i
);

    logic last_step;

    assign last_step = score_ctrl_i.step && (score_ctrl_i.index == peg_idx_t'(num_pegs - 1));

    result_one_cycle: assert property (@(posedge clock) disable iff (!resetn)
        result_i |=> !result_i)
        else $error("result strobe high for more than one cycle");

    result_after_step: assert property (@(posedge clock) disable iff (!resetn)
        last_step |=> result_i)
        else $error("no result strobe after the last scoring step");

    result_only_after_step: assert property (@(posedge clock) disable iff (!resetn)
        result_i |-> $past(last_step))
        else $error("result strobe without a preceding last scoring step");

    score_in_range: assert property (@(posedge clock) disable iff (!resetn)
        ({1'b0, score_i.red} + {1'b0, score_i.white}) <= 4'd4)
        else $error("red plus white exceeds four");

    step_clear_exclusive: assert property (@(posedge clock) disable iff (!resetn)
        !(score_ctrl_i.step && score_ctrl_i.clear))
        else $error("scorer step and clear high together");

endmodule

bind mastermind_top mastermind_assert u_assert (
    .clock        (clock),
    .resetn       (resetn),
    .score_ctrl_i (score_ctrl),
    .result_i     (result_strobe),
    .score_i      (score)
);

`default_nettype wire

// File: tests/mastermind_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mastermind_tb
    import mastermind_pkg::*;
();

    localparam int num_codes = 100;
    localparam int guesses_per_code = 3;
    localparam int num_guesses = 2 * 5 + num_codes * guesses_per_code;
    localparam int watchdog_cycles = (num_guesses + num_codes + 1) * 200 + (num_codes + 1) * 20;

    logic       clock = 1'b0;
    logic       resetn = 1'b0;
    logic       load_i = 1'b0;
    peg_t       peg_i = '0;
    seg_t [5:0] hex_o;
    score_t     score_o;
    round_t     round_o;
    logic       result_valid_o;

    integer seed = 43;
    score_t expected_score = '0;
    round_t round_exp = '0;
    int     results_seen = 0;
    pegs_t  shown = '0;
    pegs_t  code_now;
    pegs_t  g;

    mastermind_top dut (
        .clock          (clock),
        .resetn         (resetn),
        .load_i         (load_i),
        .peg_i          (peg_i),
        .hex_o          (hex_o),
        .score_o        (score_o),
        .round_o        (round_o),
        .result_valid_o (result_valid_o)
    );

    always #5 clock = ~clock;

    // red from positions, white from per-colour minimum counts
    function automatic score_t score_ref(input pegs_t code, input pegs_t guess);
        int     red;
        int     both;
        int     nc;
        int     ng;
        score_t s;
        red = 0;
        both = 0;
        for (int i = 0; i < num_pegs; i++) begin
            if (code[i] == guess[i]) red++;
        end
        for (int c = 0; c < 8; c++) begin
            nc = 0;
            ng = 0;
            for (int i = 0; i < num_pegs; i++) begin
                if (code[i] == peg_t'(c)) nc++;
                if (guess[i] == peg_t'(c)) ng++;
            end
            both += (nc < ng) ? nc : ng;
        end
        s.red = count_t'(red);
        s.white = count_t'(both - red);
        return s;
    endfunction

    function automatic seg_t seg_ref(input logic [3:0] d);
        seg_t table_q [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                               7'h00, 7'h18, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};
        return table_q[d];
    endfunction

    function automatic pegs_t random_pegs(input int colours);
        pegs_t p;
        for (int i = 0; i < num_pegs; i++) begin
            p[i] = peg_t'($unsigned($random(seed)) % colours);
        end
        return p;
    endfunction

    function automatic pegs_t pegs_of(input peg_t p0, input peg_t p1, input peg_t p2,
                                      input peg_t p3);
        return {p3, p2, p1, p0};
    endfunction

    task automatic report_mismatch(input string what, input int got, input int want);
        $display("error: %0t ns: %s is %0h, expected %0h", $time, what, got, want);
        $display("TEST FAILED");
        $fatal(1, "mismatch on %s", what);
    endtask

    task automatic apply_reset();
        @(posedge clock);
        resetn <= 1'b0;
        load_i <= 1'b0;
        repeat (10) @(posedge clock);
        resetn <= 1'b1;
        shown = '0;
    endtask

    // peg_i changes while held, only the value at the press counts
    task automatic press_peg(input peg_t value);
        int gap_len;
        int hold_len;
        gap_len = 1 + $unsigned($random(seed)) % 4;
        hold_len = 1 + $unsigned($random(seed)) % 4;
        repeat (gap_len) @(posedge clock);
        load_i <= 1'b1;
        peg_i <= value;
        repeat (hold_len) begin
            @(posedge clock);
            peg_i <= peg_t'($random(seed));
        end
        load_i <= 1'b0;
        @(posedge clock);
    endtask

    task automatic enter_code(input pegs_t code);
        for (int i = 0; i < num_pegs; i++) begin
            press_peg(code[i]);
        end
    endtask

    task automatic enter_guess(input pegs_t guess, input score_t want);
        for (int i = 0; i < num_pegs; i++) begin
            press_peg(guess[i]);
            shown[i] = guess[i];
            for (int j = 0; j < num_pegs; j++) begin
                assert (hex_o[j] == seg_ref({1'b0, shown[j]}))
                    else report_mismatch("guess digit", hex_o[j], seg_ref({1'b0, shown[j]}));
            end
        end
        expected_score = want;
        // four scoring cycles, then the result cycle
        for (int c = 1; c <= 5; c++) begin
            @(posedge clock);
            assert (result_valid_o == (c == 5))
                else report_mismatch("result strobe", result_valid_o, (c == 5) ? 1 : 0);
        end
    endtask

    always @(posedge clock) begin
        if (!resetn) begin
            round_exp = '0;
        end else if (result_valid_o) begin
            assert (score_o == expected_score)
                else report_mismatch("score", score_o, expected_score);
            assert (hex_o[4] == seg_ref({1'b0, expected_score.red}))
                else report_mismatch("red digit", hex_o[4], seg_ref({1'b0, expected_score.red}));
            assert (hex_o[5] == seg_ref({1'b0, expected_score.white}))
                else report_mismatch("white digit", hex_o[5],
                                     seg_ref({1'b0, expected_score.white}));
            assert (round_o == round_exp)
                else report_mismatch("round", round_o, round_exp);
            round_exp = round_exp + round_t'(1);
            results_seen++;
        end
    end

    initial begin
        #(watchdog_cycles * 10);
        $display("error: %0t ns: timeout, the game did not finish its guesses", $time);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        apply_reset();
        @(posedge clock);
        assert (!result_valid_o && score_o == '0 && round_o == '0)
            else report_mismatch("state after reset", {result_valid_o, score_o, round_o}, 0);
        for (int j = 0; j < 6; j++) begin
            assert (hex_o[j] == seg_ref(4'd0))
                else report_mismatch("digit after reset", hex_o[j], seg_ref(4'd0));
        end

        // ten rounds on one code, so the round counter wraps
        code_now = pegs_of(3'd1, 3'd2, 3'd3, 3'd4);
        enter_code(code_now);
        for (int pass = 0; pass < 2; pass++) begin
            enter_guess(pegs_of(3'd1, 3'd2, 3'd3, 3'd4), '{red: 3'd4, white: 3'd0});
            enter_guess(pegs_of(3'd2, 3'd3, 3'd4, 3'd1), '{red: 3'd0, white: 3'd4});
            enter_guess(pegs_of(3'd3, 3'd3, 3'd3, 3'd3), '{red: 3'd1, white: 3'd0});
            enter_guess(pegs_of(3'd4, 3'd4, 3'd0, 3'd0), '{red: 3'd0, white: 3'd1});
            enter_guess(pegs_of(3'd5, 3'd6, 3'd7, 3'd0), '{red: 3'd0, white: 3'd0});
        end

        // narrow palette on odd codes gives more matches
        for (int t = 0; t < num_codes; t++) begin
            apply_reset();
            code_now = random_pegs((t % 2 == 1) ? 4 : 8);
            enter_code(code_now);
            for (int n = 0; n < guesses_per_code; n++) begin
                g = random_pegs((t % 2 == 1) ? 4 : 8);
                enter_guess(g, score_ref(code_now, g));
            end
        end

        repeat (2) @(posedge clock);
        if (results_seen != num_guesses) begin
            $display("error: %0t ns: saw %0d results, expected %0d", $time, results_seen,
                     num_guesses);
            $display("TEST FAILED");
            $fatal(1, "result count wrong");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
